/* hdl/ooo_engine_pkg.sv */
package ooo_engine_pkg;

    // which functional unit takes the issued op
    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_BR  = 2'd1,
        FU_LS  = 2'd2,
        FU_MD  = 2'd3
    } fu_target_e;

    // funct3 of OP / OP-IMM, alt bit picks sub or sra
    typedef enum logic [2:0] {
        ALU_ADD_SUB = 3'b000,
        ALU_SLL     = 3'b001,
        ALU_SLT     = 3'b010,
        ALU_SLTU    = 3'b011,
        ALU_XOR     = 3'b100,
        ALU_SRL_SRA = 3'b101,
        ALU_OR      = 3'b110,
        ALU_AND     = 3'b111
    } alu_op_e;

    // funct3 of conditional branches
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_op_e;

    // funct3 of loads and stores, unsigned forms share the width
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_width_e;

    // funct3 of the unsigned M-extension subset
    typedef enum logic [2:0] {
        MD_MUL   = 3'b000,
        MD_MULHU = 3'b011,
        MD_DIVU  = 3'b101,
        MD_REMU  = 3'b111
    } md_op_e;

endpackage

/* hdl/fu_issue_if.sv */
`timescale 1ns/1ns

// operands of one issued op, shared by all units
interface fu_issue_if #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 5
) ();
    logic [TAG_W-1:0] tag;
    logic [2:0]       funct3;
    logic             alt;
    logic [XLEN-1:0]  rs1;
    logic [XLEN-1:0]  rs2;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  offset;

    modport driver (output tag, funct3, alt, rs1, rs2, pc, offset);
    modport receiver (input tag, funct3, alt, rs1, rs2, pc, offset);
endinterface

// held result of one unit towards writeback
interface fu_result_if #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 5
) ();
    logic             valid;
    logic             ready;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
    logic             flag;

    modport source (output valid, tag, value, flag, input ready);
    modport sink (input valid, tag, value, flag, output ready);
endinterface

/* hdl/int_alu_fu.sv */
`timescale 1ns/1ns

module int_alu_fu import ooo_engine_pkg::*; #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 5
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    output logic         accept,
    fu_issue_if.receiver iss,
    fu_result_if.source  res
);

    alu_op_e                op;
    logic [4:0]             shamt;
    logic signed [XLEN-1:0] sra_res;
    logic [XLEN-1:0]        result;
    logic                   valid_q;
    logic [TAG_W-1:0]       tag_q;
    logic [XLEN-1:0]        value_q;

    assign op    = alu_op_e'(iss.funct3);
    assign shamt = iss.rs2[4:0];
    // kept apart so the shift stays arithmetic
    assign sra_res = $signed(iss.rs1) >>> shamt;

    always_comb begin
        case (op)
            ALU_ADD_SUB: begin
                if (iss.alt) begin
                    result = iss.rs1 - iss.rs2;
                end else begin
                    result = iss.rs1 + iss.rs2;
                end
            end
            ALU_SLL:  result = iss.rs1 << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(iss.rs1) < $signed(iss.rs2)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, iss.rs1 < iss.rs2};
            ALU_XOR:  result = iss.rs1 ^ iss.rs2;
            ALU_SRL_SRA: begin
                if (iss.alt) begin
                    result = sra_res;
                end else begin
                    result = iss.rs1 >> shamt;
                end
            end
            ALU_OR:   result = iss.rs1 | iss.rs2;
            default:  result = iss.rs1 & iss.rs2;
        endcase
    end

    // valid set by start, cleared once writeback takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (start) begin
            valid_q <= 1'b1;
        end else if (res.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tag_q   <= iss.tag;
            value_q <= result;
        end
    end

    // one op in flight
    assign accept    = !valid_q;
    assign res.valid = valid_q;
    assign res.tag   = tag_q;
    assign res.value = value_q;
    assign res.flag  = 1'b0;

    // result must not move while writeback stalls
    assert property (@(posedge clk) disable iff (rst)
        res.valid && !res.ready |=> res.valid && $stable(res.value));

endmodule

/* hdl/br_fu.sv */
`timescale 1ns/1ns

module br_fu import ooo_engine_pkg::*; #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 5
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    output logic         accept,
    fu_issue_if.receiver iss,
    fu_result_if.source  res
);

    br_op_e           op;
    logic             taken;
    logic [XLEN-1:0]  next_pc;
    logic             valid_q;
    logic [TAG_W-1:0] tag_q;
    logic [XLEN-1:0]  value_q;
    logic             taken_q;

    assign op = br_op_e'(iss.funct3);

    always_comb begin
        case (op)
            BR_BEQ:  taken = (iss.rs1 == iss.rs2);
            BR_BNE:  taken = (iss.rs1 != iss.rs2);
            BR_BLT:  taken = ($signed(iss.rs1) < $signed(iss.rs2));
            BR_BGE:  taken = ($signed(iss.rs1) >= $signed(iss.rs2));
            BR_BLTU: taken = (iss.rs1 < iss.rs2);
            BR_BGEU: taken = (iss.rs1 >= iss.rs2);
            default: taken = 1'b0;
        endcase
    end

    // target when taken, else fall through
    assign next_pc = taken ? iss.pc + iss.offset : iss.pc + XLEN'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (start) begin
            valid_q <= 1'b1;
        end else if (res.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tag_q   <= iss.tag;
            value_q <= next_pc;
            taken_q <= taken;
        end
    end

    assign accept    = !valid_q;
    assign res.valid = valid_q;
    assign res.tag   = tag_q;
    assign res.value = value_q;
    // flag carries the taken bit
    assign res.flag  = taken_q;

endmodule

/* hdl/ld_st_fu.sv */
`timescale 1ns/1ns

module ld_st_fu import ooo_engine_pkg::*; #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 5
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    output logic         accept,
    fu_issue_if.receiver iss,
    fu_result_if.source  res
);

    ls_width_e        width;
    logic [XLEN-1:0]  addr;
    logic             misaligned;
    logic             valid_q;
    logic [TAG_W-1:0] tag_q;
    logic [XLEN-1:0]  addr_q;
    logic             mis_q;

    assign width = ls_width_e'(iss.funct3);
    assign addr  = iss.rs1 + iss.offset;

    // bytes are always aligned
    always_comb begin
        case (width)
            LS_H, LS_HU: misaligned = addr[0];
            LS_W:        misaligned = |addr[1:0];
            default:     misaligned = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (start) begin
            valid_q <= 1'b1;
        end else if (res.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tag_q  <= iss.tag;
            addr_q <= addr;
            mis_q  <= misaligned;
        end
    end

    assign accept    = !valid_q;
    assign res.valid = valid_q;
    assign res.tag   = tag_q;
    assign res.value = addr_q;
    assign res.flag  = mis_q;

endmodule

/* hdl/md_fu.sv */
`timescale 1ns/1ns

module md_fu import ooo_engine_pkg::*; #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 5
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    output logic         accept,
    fu_issue_if.receiver iss,
    fu_result_if.source  res
);

    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_RUN,
        MD_DONE
    } md_state_e;

    md_state_e        state;
    logic [CNT_W-1:0] cnt;
    md_op_e           op_in;
    logic             div_in;
    md_op_e           op_q;
    logic             div_q;
    logic [TAG_W-1:0] tag_q;
    logic             dz_q;
    // {acc_hi, acc_lo} is the product, or remainder and quotient
    logic [XLEN:0]    acc_hi;
    logic [XLEN-1:0]  acc_lo;
    // multiplicand or divisor
    logic [XLEN-1:0]  opnd;
    logic [XLEN:0]    mul_sum;
    logic [XLEN:0]    div_shift;
    logic [XLEN:0]    div_diff;

    assign op_in  = md_op_e'(iss.funct3);
    assign div_in = (op_in == MD_DIVU) || (op_in == MD_REMU);

    // one shift-and-add step
    assign mul_sum = {1'b0, acc_hi[XLEN-1:0]} + {1'b0, (acc_lo[0] ? opnd : '0)};
    // one restoring divide step
    assign div_shift = {acc_hi[XLEN-1:0], acc_lo[XLEN-1]};
    assign div_diff  = div_shift - {1'b0, opnd};

    // load on start, 32 steps, hold until writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MD_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                MD_IDLE: begin
                    if (start) begin
                        state <= MD_RUN;
                        cnt   <= '0;
                    end
                end
                MD_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(XLEN-1)) begin
                        state <= MD_DONE;
                    end
                end
                default: begin
                    if (res.ready) begin
                        state <= MD_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q   <= op_in;
            div_q  <= div_in;
            tag_q  <= iss.tag;
            // zero divisor runs too and lands on all ones / rs1
            dz_q   <= div_in && (iss.rs2 == '0);
            acc_hi <= '0;
            acc_lo <= div_in ? iss.rs1 : iss.rs2;
            opnd   <= div_in ? iss.rs2 : iss.rs1;
        end else if (state == MD_RUN) begin
            if (!div_q) begin
                {acc_hi, acc_lo} <= {1'b0, mul_sum, acc_lo[XLEN-1:1]};
            end else if (!div_diff[XLEN]) begin
                acc_hi <= div_diff;
                acc_lo <= {acc_lo[XLEN-2:0], 1'b1};
            end else begin
                acc_hi <= div_shift;
                acc_lo <= {acc_lo[XLEN-2:0], 1'b0};
            end
        end
    end

    assign accept    = (state == MD_IDLE);
    assign res.valid = (state == MD_DONE);
    assign res.tag   = tag_q;
    // high half for mulhu and remu
    assign res.value = (op_q == MD_MULHU || op_q == MD_REMU) ? acc_hi[XLEN-1:0] : acc_lo;
    assign res.flag  = dz_q;

    // issue must honour accept
    assert property (@(posedge clk) disable iff (rst) start |-> state == MD_IDLE);

endmodule

/* hdl/wb_arbiter.sv */
`timescale 1ns/1ns

module wb_arbiter #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 5
) (
    input  logic             clk,
    input  logic             rst,
    fu_result_if.sink        src_md,
    fu_result_if.sink        src_br,
    fu_result_if.sink        src_ls,
    fu_result_if.sink        src_alu,
    output logic             wb_valid,
    output logic [TAG_W-1:0] wb_tag,
    output logic [XLEN-1:0]  wb_value,
    output logic             wb_flag,
    input  logic             wb_ready
);

    // fixed priority md > br > ls > alu
    always_comb begin
        src_md.ready  = 1'b0;
        src_br.ready  = 1'b0;
        src_ls.ready  = 1'b0;
        src_alu.ready = 1'b0;
        wb_valid      = 1'b1;
        if (src_md.valid) begin
            {wb_tag, wb_value, wb_flag} = {src_md.tag, src_md.value, src_md.flag};
            src_md.ready = wb_ready;
        end else if (src_br.valid) begin
            {wb_tag, wb_value, wb_flag} = {src_br.tag, src_br.value, src_br.flag};
            src_br.ready = wb_ready;
        end else if (src_ls.valid) begin
            {wb_tag, wb_value, wb_flag} = {src_ls.tag, src_ls.value, src_ls.flag};
            src_ls.ready = wb_ready;
        end else begin
            // alu result, or nothing pending
            {wb_tag, wb_value, wb_flag} = {src_alu.tag, src_alu.value, src_alu.flag};
            wb_valid      = src_alu.valid;
            src_alu.ready = wb_ready && src_alu.valid;
        end
    end

    // at most one unit released per cycle
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({src_md.ready, src_br.ready, src_ls.ready, src_alu.ready}));

endmodule

/* hdl/ooo_engine_top.sv */
`timescale 1ns/1ns

module ooo_engine_top import ooo_engine_pkg::*; #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_valid,
    input  fu_target_e       issue_target,
    input  logic [TAG_W-1:0] issue_tag,
    input  logic [2:0]       issue_funct3,
    input  logic             issue_alt,
    input  logic [XLEN-1:0]  issue_rs1,
    input  logic [XLEN-1:0]  issue_rs2,
    input  logic [XLEN-1:0]  issue_pc,
    input  logic [XLEN-1:0]  issue_offset,
    output logic             issue_ready,
    output logic             wb_valid,
    output logic [TAG_W-1:0] wb_tag,
    output logic [XLEN-1:0]  wb_value,
    output logic             wb_flag,
    input  logic             wb_ready
);

    logic accept_alu;
    logic accept_br;
    logic accept_ls;
    logic accept_md;
    logic issue_fire;

    fu_issue_if #(.XLEN(XLEN), .TAG_W(TAG_W)) iss ();
    fu_result_if #(.XLEN(XLEN), .TAG_W(TAG_W)) res_alu ();
    fu_result_if #(.XLEN(XLEN), .TAG_W(TAG_W)) res_br ();
    fu_result_if #(.XLEN(XLEN), .TAG_W(TAG_W)) res_ls ();
    fu_result_if #(.XLEN(XLEN), .TAG_W(TAG_W)) res_md ();

    // operands go to every unit, only the strobe is steered
    assign iss.tag    = issue_tag;
    assign iss.funct3 = issue_funct3;
    assign iss.alt    = issue_alt;
    assign iss.rs1    = issue_rs1;
    assign iss.rs2    = issue_rs2;
    assign iss.pc     = issue_pc;
    assign iss.offset = issue_offset;

    // ready follows the targeted unit only
    always_comb begin
        case (issue_target)
            FU_ALU:  issue_ready = accept_alu;
            FU_BR:   issue_ready = accept_br;
            FU_LS:   issue_ready = accept_ls;
            default: issue_ready = accept_md;
        endcase
    end

    assign issue_fire = issue_valid && issue_ready;

    int_alu_fu #(.XLEN(XLEN), .TAG_W(TAG_W)) alu_u (
        .clk(clk), .rst(rst), .start(issue_fire && issue_target == FU_ALU),
        .accept(accept_alu), .iss(iss), .res(res_alu)
    );

    br_fu #(.XLEN(XLEN), .TAG_W(TAG_W)) br_u (
        .clk(clk), .rst(rst), .start(issue_fire && issue_target == FU_BR),
        .accept(accept_br), .iss(iss), .res(res_br)
    );

    ld_st_fu #(.XLEN(XLEN), .TAG_W(TAG_W)) ls_u (
        .clk(clk), .rst(rst), .start(issue_fire && issue_target == FU_LS),
        .accept(accept_ls), .iss(iss), .res(res_ls)
    );

    md_fu #(.XLEN(XLEN), .TAG_W(TAG_W)) md_u (
        .clk(clk), .rst(rst), .start(issue_fire && issue_target == FU_MD),
        .accept(accept_md), .iss(iss), .res(res_md)
    );

    wb_arbiter #(.XLEN(XLEN), .TAG_W(TAG_W)) wb_arb (
        .clk(clk), .rst(rst),
        .src_md(res_md), .src_br(res_br), .src_ls(res_ls), .src_alu(res_alu),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value), .wb_flag(wb_flag),
        .wb_ready(wb_ready)
    );

endmodule

/* verification/ooo_engine_tb.sv */
`timescale 1ns/1ns

module ooo_engine_tb import ooo_engine_pkg::*; ();

    localparam int XLEN   = 32;
    localparam int TAG_W  = 5;
    localparam int MD_LAT = 33;
    // about 60 ops at up to 40 cycles each, plus margin
    localparam int MAX_CYCLES = 4000;

    logic             clk;
    logic             rst;
    logic             issue_valid;
    fu_target_e       issue_target;
    logic [TAG_W-1:0] issue_tag;
    logic [2:0]       issue_funct3;
    logic             issue_alt;
    logic [XLEN-1:0]  issue_rs1;
    logic [XLEN-1:0]  issue_rs2;
    logic [XLEN-1:0]  issue_pc;
    logic [XLEN-1:0]  issue_offset;
    logic             issue_ready;
    logic             wb_valid;
    logic [TAG_W-1:0] wb_tag;
    logic [XLEN-1:0]  wb_value;
    logic             wb_flag;
    logic             wb_ready;

    int               cycles = 0;
    int               checks = 0;
    int               errors = 0;
    logic [31:0]      lfsr = 32'h12cb_543e;
    logic [TAG_W-1:0] tag_cnt = '0;

    ooo_engine_top #(.XLEN(XLEN), .TAG_W(TAG_W)) dut0 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_target(issue_target), .issue_tag(issue_tag),
        .issue_funct3(issue_funct3), .issue_alt(issue_alt),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
        .issue_pc(issue_pc), .issue_offset(issue_offset), .issue_ready(issue_ready),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value), .wb_flag(wb_flag),
        .wb_ready(wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no progress after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [XLEN-1:0] rand_bits(input int n);
        logic [XLEN-1:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
            r = {r[XLEN-2:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [TAG_W-1:0] next_tag();
        tag_cnt = tag_cnt + 1'b1;
        return tag_cnt;
    endfunction

    task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: got %h expected %h (cycle %0d)", name, got, want, cycles);
        end
    endtask

    task automatic compare_tag(input string name, input logic [TAG_W-1:0] got,
                               input logic [TAG_W-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: got %h expected %h (cycle %0d)", name, got, want, cycles);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: got %h expected %h (cycle %0d)", name, got, want, cycles);
        end
    endtask

    // called 2ns after an edge, returns 2ns after the handshake edge
    task automatic issue_op(input fu_target_e target, input logic [2:0] funct3,
                            input logic alt, input logic [XLEN-1:0] rs1,
                            input logic [XLEN-1:0] rs2, input logic [XLEN-1:0] pc,
                            input logic [XLEN-1:0] offset, input logic [TAG_W-1:0] tag,
                            output int hs_cyc);
        issue_valid  = 1'b1;
        issue_target = target;
        issue_funct3 = funct3;
        issue_alt    = alt;
        issue_rs1    = rs1;
        issue_rs2    = rs2;
        issue_pc     = pc;
        issue_offset = offset;
        issue_tag    = tag;
        @(negedge clk);
        compare_flag("issue_ready", issue_ready, 1'b1);
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
        hs_cyc = cycles;
    endtask

    // a busy unit must refuse a pending issue
    task automatic probe_busy(input fu_target_e target);
        issue_valid  = 1'b1;
        issue_target = target;
        @(negedge clk);
        compare_flag("issue_ready", issue_ready, 1'b0);
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
    endtask

    // wait for wb_valid, check it, let it leave on the next edge
    task automatic collect(input logic [TAG_W-1:0] want_tag, input logic [XLEN-1:0] want_value,
                           input logic want_flag, input int hs_cyc, input int want_lat);
        int lat;
        @(negedge clk);
        while (!wb_valid) begin
            @(negedge clk);
        end
        // edges since the handshake, counting that one
        lat = cycles - hs_cyc + 1;
        if (want_lat != 0) begin
            checks++;
            if (lat != want_lat) begin
                errors++;
                $display("wb_valid came %0d cycles after issue instead of %0d", lat, want_lat);
            end
        end
        compare_tag("wb_tag", wb_tag, want_tag);
        compare_value("wb_value", wb_value, want_value);
        compare_flag("wb_flag", wb_flag, want_flag);
        @(posedge clk);
        #2;
    endtask

    task automatic test_alu();
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        logic [XLEN-1:0]        want;
        logic signed [XLEN-1:0] sa;
        logic [4:0]             sh;
        logic [TAG_W-1:0]       tag;
        int                     hs;
        for (int fi = 0; fi < 8; fi++) begin
            for (int ai = 0; ai < 2; ai++) begin
                // alt only means something for add/sub and srl/sra
                if (ai == 0 || fi == 0 || fi == 5) begin
                    a   = rand_bits(XLEN);
                    b   = rand_bits(XLEN);
                    sa  = a;
                    sh  = b[4:0];
                    tag = next_tag();
                    case (alu_op_e'(fi))
                        ALU_ADD_SUB: want = (ai == 1) ? a - b : a + b;
                        ALU_SLL:     want = a << sh;
                        ALU_SLT:     want = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        ALU_SLTU:    want = (a < b) ? 32'd1 : 32'd0;
                        ALU_XOR:     want = a ^ b;
                        ALU_SRL_SRA: begin
                            if (ai == 1) begin
                                want = sa >>> sh;
                            end else begin
                                want = a >> sh;
                            end
                        end
                        ALU_OR:      want = a | b;
                        default:     want = a & b;
                    endcase
                    issue_op(FU_ALU, 3'(fi), ai[0], a, b, '0, '0, tag, hs);
                    collect(tag, want, 1'b0, hs, 1);
                end
            end
        end
    endtask

    task automatic test_branch();
        logic [XLEN-1:0]  lhs [5];
        logic [XLEN-1:0]  rhs [5];
        br_op_e           ops [6];
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  off;
        logic             taken;
        logic [TAG_W-1:0] tag;
        int               hs;
        // equal, less, greater, then sign cases
        lhs = '{32'd5, 32'd3, 32'd9, 32'hffff_fff0, 32'd7};
        rhs = '{32'd5, 32'd9, 32'd3, 32'd7, 32'hffff_fff0};
        ops = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        for (int oi = 0; oi < 6; oi++) begin
            for (int pi = 0; pi < 5; pi++) begin
                case (ops[oi])
                    BR_BEQ:  taken = (lhs[pi] == rhs[pi]);
                    BR_BNE:  taken = (lhs[pi] != rhs[pi]);
                    BR_BLT:  taken = ($signed(lhs[pi]) < $signed(rhs[pi]));
                    BR_BGE:  taken = !($signed(lhs[pi]) < $signed(rhs[pi]));
                    BR_BLTU: taken = (lhs[pi] < rhs[pi]);
                    default: taken = !(lhs[pi] < rhs[pi]);
                endcase
                pc  = rand_bits(XLEN) & ~32'd3;
                off = rand_bits(XLEN) & ~32'd1;
                tag = next_tag();
                issue_op(FU_BR, ops[oi], 1'b0, lhs[pi], rhs[pi], pc, off, tag, hs);
                collect(tag, taken ? pc + off : pc + 32'd4, taken, hs, 1);
            end
        end
    endtask

    task automatic test_ld_st();
        ls_width_e        widths [4];
        logic [XLEN-1:0]  base;
        logic [XLEN-1:0]  off;
        logic [XLEN-1:0]  addr;
        logic             mis;
        logic [TAG_W-1:0] tag;
        int               hs;
        widths = '{LS_B, LS_H, LS_W, LS_HU};
        for (int wi = 0; wi < 4; wi++) begin
            // low offset bits walk all four byte lanes
            for (int lo = 0; lo < 4; lo++) begin
                base = rand_bits(XLEN) & ~32'd3;
                off  = (rand_bits(10) << 2) | XLEN'(lo);
                addr = base + off;
                case (widths[wi])
                    LS_H, LS_HU: mis = addr[0];
                    LS_W:        mis = addr[1] | addr[0];
                    default:     mis = 1'b0;
                endcase
                tag = next_tag();
                issue_op(FU_LS, widths[wi], 1'b0, base, '0, '0, off, tag, hs);
                collect(tag, addr, mis, hs, 1);
            end
        end
    endtask

    task automatic test_md();
        md_op_e            ops [4];
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [2*XLEN-1:0] prod;
        logic [XLEN-1:0]   want;
        logic              dz;
        logic              is_div;
        logic [TAG_W-1:0]  tag;
        int                hs;
        ops = '{MD_MUL, MD_MULHU, MD_DIVU, MD_REMU};
        // second pass repeats the divides with a zero divisor
        for (int pass = 0; pass < 2; pass++) begin
            for (int oi = 0; oi < 4; oi++) begin
                is_div = (ops[oi] == MD_DIVU) || (ops[oi] == MD_REMU);
                if (pass == 0 || is_div) begin
                    a = rand_bits(XLEN);
                    if (pass == 1) begin
                        b = '0;
                    end else if (is_div) begin
                        b = rand_bits(16) | 32'd1;
                    end else begin
                        b = rand_bits(XLEN);
                    end
                    prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
                    dz   = is_div && (b == '0);
                    case (ops[oi])
                        MD_MUL:   want = prod[XLEN-1:0];
                        MD_MULHU: want = prod[2*XLEN-1:XLEN];
                        MD_DIVU:  want = dz ? '1 : a / b;
                        default:  want = dz ? a : a % b;
                    endcase
                    tag = next_tag();
                    issue_op(FU_MD, ops[oi], 1'b0, a, b, '0, '0, tag, hs);
                    collect(tag, want, dz, hs, MD_LAT);
                end
            end
        end
    endtask

    task automatic test_backpressure();
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [XLEN-1:0]  base;
        logic [XLEN-1:0]  off;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  br_off;
        logic [TAG_W-1:0] t_alu;
        logic [TAG_W-1:0] t_ls;
        logic [TAG_W-1:0] t_br;
        int               hs;
        a      = rand_bits(XLEN);
        b      = rand_bits(XLEN);
        base   = rand_bits(XLEN);
        off    = rand_bits(XLEN);
        pc     = rand_bits(XLEN) & ~32'd3;
        br_off = rand_bits(XLEN) & ~32'd1;
        t_alu  = next_tag();
        t_ls   = next_tag();
        t_br   = next_tag();
        wb_ready = 1'b0;
        issue_op(FU_ALU, ALU_XOR, 1'b0, a, b, '0, '0, t_alu, hs);
        issue_op(FU_LS, LS_W, 1'b0, base, '0, '0, off, t_ls, hs);
        // beq on equal operands, always taken
        issue_op(FU_BR, BR_BEQ, 1'b0, a, a, pc, br_off, t_br, hs);
        probe_busy(FU_ALU);
        probe_busy(FU_LS);
        probe_busy(FU_BR);
        wb_ready = 1'b1;
        // drain order follows priority
        collect(t_br, pc + br_off, 1'b1, hs, 0);
        collect(t_ls, base + off, |(base[1:0] + off[1:0]), hs, 0);
        collect(t_alu, a ^ b, 1'b0, hs, 0);
    endtask

    task automatic test_md_overlap();
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [2*XLEN-1:0] prod;
        logic [XLEN-1:0]   x;
        logic [XLEN-1:0]   y;
        logic [TAG_W-1:0]  t_md;
        logic [TAG_W-1:0]  tag;
        int                hs_md;
        int                hs;
        a    = rand_bits(XLEN);
        b    = rand_bits(XLEN);
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        t_md = next_tag();
        issue_op(FU_MD, MD_MUL, 1'b0, a, b, '0, '0, t_md, hs_md);
        probe_busy(FU_MD);
        // alu keeps flowing under the long multiply
        for (int i = 0; i < 3; i++) begin
            x   = rand_bits(XLEN);
            y   = rand_bits(XLEN);
            tag = next_tag();
            issue_op(FU_ALU, ALU_ADD_SUB, 1'b0, x, y, '0, '0, tag, hs);
            collect(tag, x + y, 1'b0, hs, 1);
        end
        probe_busy(FU_MD);
        collect(t_md, prod[XLEN-1:0], 1'b0, hs_md, MD_LAT);
    endtask

    initial begin
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_target = FU_ALU;
        issue_tag    = '0;
        issue_funct3 = '0;
        issue_alt    = 1'b0;
        issue_rs1    = '0;
        issue_rs2    = '0;
        issue_pc     = '0;
        issue_offset = '0;
        wb_ready     = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        // idle after reset
        @(negedge clk);
        compare_flag("wb_valid", wb_valid, 1'b0);
        compare_flag("issue_ready", issue_ready, 1'b1);
        @(posedge clk);
        #2;
        test_alu();
        test_branch();
        test_ld_st();
        test_md();
        test_backpressure();
        test_md_overlap();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
hdl/ooo_engine_pkg.sv
hdl/fu_issue_if.sv
hdl/int_alu_fu.sv
hdl/br_fu.sv
hdl/ld_st_fu.sv
hdl/md_fu.sv
hdl/wb_arbiter.sv
hdl/ooo_engine_top.sv
verification/ooo_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module ooo_engine_tb -f flist.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vooo_engine_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" <<< "$output"; then
    exit 0
fi
exit 1
